//--- verilog/lcd_pkg.sv
/*
 * ST7735 controller package
 * SPI widths, the RAMWR code and the power-up command table
 * with its DC flags and per-entry pauses
 */
package lcd_pkg;

   localparam int BYTE_W  = 8;
   localparam int COLOR_W = 16;   // rgb565

   localparam logic [BYTE_W-1:0] CMD_RAMWR = 8'h2C;

   localparam int INIT_LEN = 34;   // ends with RAMWR

   // send order, entry 0 first
   localparam logic [0:INIT_LEN-1][BYTE_W-1:0] INIT_BYTES = {
      8'h01,                        // SWRESET
      8'h11,                        // SLPOUT
      8'hB4, 8'h07,                 // INVCTR
      8'hC0, 8'hA2, 8'h02, 8'h84,   // PWCTR1
      8'hC3, 8'h8A, 8'h2A,          // PWCTR4
      8'hC4, 8'h8A, 8'hEE,          // PWCTR5
      8'hC5, 8'h0E,                 // VMCTR1
      8'h21,                        // INVON
      8'h36, 8'hC8,                 // MADCTL
      8'h3A, 8'h05,                 // COLMOD, 16 bit/pixel
      8'h2A, 8'h00, 8'h1A, 8'h00, 8'h6A,   // CASET
      8'h2B, 8'h00, 8'h01, 8'h00, 8'hA2,   // RASET
      8'h13,                        // NORON
      8'h29,                        // DISPON
      CMD_RAMWR
   };

   // 1 marks a parameter byte (dc high)
   localparam logic [0:INIT_LEN-1] INIT_IS_DATA =
      34'b0001_0111_0110_1101_0010_1011_1101_1110_00;

   // pause after each entry in ms
   localparam logic [0:INIT_LEN-1][9:0] INIT_DELAY_MS = {
      10'd150, 10'd500, {29{10'd0}}, 10'd10, 10'd100, 10'd0
   };

endpackage

//--- verilog/panel_reset_gen.sv
`timescale 1ns/1ns
/*
 * panel reset generator
 * holds the panel hardware reset low after power-up, then signals
 * ready once the panel has had time to settle
 */
module panel_reset_gen #(
   parameter int RESET_LOW_CYCLES  = 120000,
   parameter int RESET_WAIT_CYCLES = 1440000
) (
   input  logic clk,
   input  logic rst_n,
   output logic panel_rst,
   output logic panel_ready
);

   localparam int TOTAL = RESET_LOW_CYCLES + RESET_WAIT_CYCLES;
   localparam int CNT_W = $clog2(TOTAL + 1);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (cnt != CNT_W'(TOTAL)) begin
         cnt <= cnt + 1'b1;   // stops at the end
      end
   end

   assign panel_rst   = (cnt >= CNT_W'(RESET_LOW_CYCLES));
   assign panel_ready = (cnt == CNT_W'(TOTAL));

endmodule

//--- verilog/spi_byte_tx.sv
`timescale 1ns/1ns
/*
 * SPI byte serializer
 * shifts one byte MSB first with CS low for exactly that byte.
 * SCK idles high and is only toggled while shifting
 */
module spi_byte_tx import lcd_pkg::*; #(
   parameter int HALF_SCK_CYCLES = 1
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              tx_start,
   input  logic              tx_dc,
   input  logic [BYTE_W-1:0] tx_byte,
   output logic              tx_busy,
   output logic              tx_done,
   output logic              lcd_sck,
   output logic              lcd_mosi,
   output logic              lcd_dc,
   output logic              lcd_cs
);

   localparam int HC_W  = (HALF_SCK_CYCLES > 1) ? $clog2(HALF_SCK_CYCLES) : 1;
   localparam int BIT_W = $clog2(BYTE_W);

   logic [HC_W-1:0]   half_cnt;
   logic [BIT_W-1:0]  bit_cnt;
   logic [BYTE_W-1:0] shreg;
   logic              half_end;

   assign half_end = (half_cnt == HC_W'(HALF_SCK_CYCLES - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_busy  <= 1'b0;
         tx_done  <= 1'b0;
         half_cnt <= '0;
         bit_cnt  <= '0;
         lcd_sck  <= 1'b1;
         lcd_cs   <= 1'b1;
         lcd_dc   <= 1'b0;
         lcd_mosi <= 1'b0;
      end else begin
         tx_done <= 1'b0;
         if (!tx_busy) begin
            if (tx_start) begin
               tx_busy  <= 1'b1;
               lcd_cs   <= 1'b0;
               lcd_dc   <= tx_dc;
               lcd_sck  <= 1'b0;
               lcd_mosi <= tx_byte[BYTE_W-1];   // first bit goes out with cs
               half_cnt <= '0;
               bit_cnt  <= '0;
            end
         end else if (half_end) begin
            half_cnt <= '0;
            if (!lcd_sck) begin
               lcd_sck <= 1'b1;   // panel samples mosi here
            end else if (bit_cnt == BIT_W'(BYTE_W - 1)) begin
               tx_busy <= 1'b0;
               lcd_cs  <= 1'b1;
               tx_done <= 1'b1;
            end else begin
               lcd_sck  <= 1'b0;
               lcd_mosi <= shreg[BYTE_W-1];
               bit_cnt  <= bit_cnt + 1'b1;
            end
         end else begin
            half_cnt <= half_cnt + 1'b1;
         end
      end
   end

   // remaining bits of the current byte
   always_ff @(posedge clk) begin
      if (!tx_busy && tx_start) begin
         shreg <= {tx_byte[BYTE_W-2:0], 1'b0};
      end else if (tx_busy && half_end && lcd_sck) begin
         shreg <= {shreg[BYTE_W-2:0], 1'b0};
      end
   end

   a_cs_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !tx_busy |-> lcd_cs);

   // the arbiter must not forward a start into a running byte
   a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
      tx_busy |-> !tx_start);

endmodule

//--- verilog/lcd_init_seq.sv
`timescale 1ns/1ns
/*
 * LCD init sequencer
 * sends the power-up table one byte per entry once the panel is out of
 * reset, and waits out the pauses some commands need
 */
module lcd_init_seq import lcd_pkg::*; #(
   parameter int CYCLES_PER_MS = 12000
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              panel_ready,
   input  logic              grant,
   input  logic              done_byte,
   output logic              req,
   output logic              start,
   output logic              dc,
   output logic              init_done,
   output logic [BYTE_W-1:0] byte_out
);

   localparam int IDX_W = $clog2(INIT_LEN);
   localparam int DLY_W = $clog2(1024 * CYCLES_PER_MS);

   localparam logic [2:0] ST_WAIT_PANEL = 3'd0;
   localparam logic [2:0] ST_REQ        = 3'd1;
   localparam logic [2:0] ST_ISSUE      = 3'd2;
   localparam logic [2:0] ST_BUSY       = 3'd3;
   localparam logic [2:0] ST_PAUSE      = 3'd4;
   localparam logic [2:0] ST_END        = 3'd5;

   logic [2:0]       state;
   logic [IDX_W-1:0] idx;
   logic [DLY_W-1:0] dly_cnt;
   logic [9:0]       cur_delay;
   logic             last;
   logic             advance;

   assign cur_delay = INIT_DELAY_MS[idx];
   assign last      = (idx == IDX_W'(INIT_LEN - 1));

   // entry finished, with or without a pause
   assign advance = (state == ST_BUSY && done_byte && cur_delay == '0) ||
                    (state == ST_PAUSE && dly_cnt == '0);

   assign req      = (state != ST_WAIT_PANEL) && (state != ST_END);
   assign start    = (state == ST_ISSUE);
   assign byte_out = INIT_BYTES[idx];
   assign dc       = INIT_IS_DATA[idx];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_WAIT_PANEL;
         idx       <= '0;
         dly_cnt   <= '0;
         init_done <= 1'b0;
      end else begin
         init_done <= 1'b0;
         if (advance) begin
            if (last) begin
               state     <= ST_END;
               init_done <= 1'b1;
            end else begin
               idx   <= idx + 1'b1;
               state <= ST_ISSUE;   // next start one cycle after done
            end
         end else begin
            case (state)
               ST_WAIT_PANEL: begin
                  if (panel_ready) begin
                     state <= ST_REQ;
                  end
               end
               ST_REQ: begin
                  if (grant) begin
                     state <= ST_ISSUE;
                  end
               end
               ST_ISSUE: begin
                  state <= ST_BUSY;
               end
               ST_BUSY: begin
                  if (done_byte) begin   // only reached with a pause pending
                     dly_cnt <= DLY_W'(32'(cur_delay) * CYCLES_PER_MS);
                     state   <= ST_PAUSE;
                  end
               end
               ST_PAUSE: begin
                  dly_cnt <= dly_cnt - 1'b1;   // bus stays owned meanwhile
               end
               default: begin
               end
            endcase
         end
      end
   end

   // grant is held for the whole table once given
   a_start_granted: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> grant);

endmodule

//--- verilog/pixel_streamer.sv
`timescale 1ns/1ns
/*
 * pixel streamer
 * clears the panel with one black frame, then streams frames forever,
 * asking the outside for each pixel colour in raster order
 */
module pixel_streamer import lcd_pkg::*; #(
   parameter int SCREEN_WIDTH  = 160,
   parameter int SCREEN_HEIGHT = 80
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             init_done,
   input  logic                             grant,
   input  logic                             done_byte,
   input  logic [COLOR_W-1:0]               color,
   output logic                             req,
   output logic                             start,
   output logic                             dc,
   output logic                             next_pixel,
   output logic                             is_init,
   output logic [BYTE_W-1:0]                byte_out,
   output logic [$clog2(SCREEN_WIDTH)-1:0]  x,
   output logic [$clog2(SCREEN_HEIGHT)-1:0] y
);

   localparam int XW = $clog2(SCREEN_WIDTH);
   localparam int YW = $clog2(SCREEN_HEIGHT);

   localparam logic [2:0] ST_IDLE   = 3'd0;
   localparam logic [2:0] ST_CMD    = 3'd1;
   localparam logic [2:0] ST_PIX    = 3'd2;
   localparam logic [2:0] ST_SAMPLE = 3'd3;
   localparam logic [2:0] ST_HI     = 3'd4;
   localparam logic [2:0] ST_LO     = 3'd5;

   logic [2:0]         state;
   logic               pending;   // byte handed to the serializer
   logic [COLOR_W-1:0] color_q;
   logic               frame_end;
   logic               sending;

   assign sending   = (state == ST_CMD) || (state == ST_HI) || (state == ST_LO);
   assign frame_end = (x == XW'(SCREEN_WIDTH - 1)) && (y == YW'(SCREEN_HEIGHT - 1));

   assign req        = (state != ST_IDLE);
   assign start      = sending && grant && !pending;
   assign next_pixel = (state == ST_PIX) && is_init;   // silent in the black frame
   assign dc         = (state != ST_CMD);

   always_comb begin
      case (state)
         ST_CMD:  byte_out = CMD_RAMWR;
         ST_HI:   byte_out = color_q[COLOR_W-1:BYTE_W];
         default: byte_out = color_q[BYTE_W-1:0];
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ST_IDLE;
         pending <= 1'b0;
         is_init <= 1'b0;
         x       <= '0;
         y       <= '0;
      end else begin
         if (start) begin
            pending <= 1'b1;
         end else if (done_byte) begin
            pending <= 1'b0;
         end
         case (state)
            ST_IDLE: begin
               if (init_done) begin
                  state <= ST_PIX;   // init table already ended with RAMWR
               end
            end
            ST_CMD: begin
               if (done_byte) begin
                  state <= ST_PIX;
               end
            end
            ST_PIX: begin
               state <= ST_SAMPLE;
            end
            ST_SAMPLE: begin
               state <= ST_HI;
            end
            ST_HI: begin
               if (done_byte) begin
                  state <= ST_LO;
               end
            end
            ST_LO: begin
               if (done_byte) begin
                  if (frame_end) begin
                     x       <= '0;
                     y       <= '0;
                     is_init <= 1'b1;
                     state   <= ST_CMD;
                  end else begin
                     if (x == XW'(SCREEN_WIDTH - 1)) begin
                        x <= '0;
                        y <= y + 1'b1;
                     end else begin
                        x <= x + 1'b1;
                     end
                     state <= ST_PIX;
                  end
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // colour taken one cycle after next_pixel, black while clearing
   always_ff @(posedge clk) begin
      if (state == ST_SAMPLE) begin
         color_q <= is_init ? color : '0;
      end
   end

endmodule

//--- verilog/spi_bus_arbiter.sv
`timescale 1ns/1ns
/*
 * SPI bus arbiter
 * lends the byte serializer to the init sequencer or the pixel streamer,
 * init first, and only hands over between bytes
 */
module spi_bus_arbiter import lcd_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              init_req,
   input  logic              init_start,
   input  logic              init_dc,
   input  logic [BYTE_W-1:0] init_byte,
   input  logic              pix_req,
   input  logic              pix_start,
   input  logic              pix_dc,
   input  logic [BYTE_W-1:0] pix_byte,
   input  logic              tx_busy,
   input  logic              tx_done,
   output logic              init_grant,
   output logic              pix_grant,
   output logic              init_done_byte,
   output logic              pix_done_byte,
   output logic              tx_start,
   output logic              tx_dc,
   output logic [BYTE_W-1:0] tx_byte
);

   logic free;

   // owner let go and nothing on the wire
   assign free = !tx_busy && !(init_grant && init_req) && !(pix_grant && pix_req);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         init_grant <= 1'b0;
         pix_grant  <= 1'b0;
      end else if (free) begin
         init_grant <= init_req;
         pix_grant  <= !init_req && pix_req;
      end
   end

   assign tx_start = init_grant ? init_start : (pix_grant && pix_start);
   assign tx_dc    = init_grant ? init_dc : pix_dc;
   assign tx_byte  = init_grant ? init_byte : pix_byte;

   assign init_done_byte = init_grant && tx_done;
   assign pix_done_byte  = pix_grant && tx_done;

   a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
      !(init_grant && pix_grant));

   a_owner_stable: assert property (@(posedge clk) disable iff (!rst_n)
      tx_busy |=> $stable({init_grant, pix_grant}));

endmodule

//--- verilog/st7735_ctrl.sv
`timescale 1ns/1ns
/*
 * ST7735 LCD controller top
 * panel reset, init sequencer and pixel streamer sharing one
 * 4-wire SPI serializer through an arbiter
 */
module st7735_ctrl import lcd_pkg::*; #(
   parameter int SCREEN_WIDTH      = 160,
   parameter int SCREEN_HEIGHT     = 80,
   parameter int HALF_SCK_CYCLES   = 1,
   parameter int CYCLES_PER_MS     = 12000,
   parameter int RESET_LOW_CYCLES  = 120000,    // 10 ms at 12 MHz
   parameter int RESET_WAIT_CYCLES = 1440000    // 120 ms
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [COLOR_W-1:0]               color,
   output logic                             lcd_sck,
   output logic                             lcd_mosi,
   output logic                             lcd_dc,
   output logic                             lcd_cs,
   output logic                             panel_rst,
   output logic                             next_pixel,
   output logic                             is_init,
   output logic [$clog2(SCREEN_WIDTH)-1:0]  x,
   output logic [$clog2(SCREEN_HEIGHT)-1:0] y
);

   logic              panel_ready;
   logic              init_req;
   logic              init_start;
   logic              init_dc;
   logic [BYTE_W-1:0] init_byte;
   logic              init_grant;
   logic              init_done_byte;
   logic              init_done;
   logic              pix_req;
   logic              pix_start;
   logic              pix_dc;
   logic [BYTE_W-1:0] pix_byte;
   logic              pix_grant;
   logic              pix_done_byte;
   logic              tx_start;
   logic              tx_dc;
   logic [BYTE_W-1:0] tx_byte;
   logic              tx_busy;
   logic              tx_done;

   panel_reset_gen #(
      .RESET_LOW_CYCLES (RESET_LOW_CYCLES),
      .RESET_WAIT_CYCLES(RESET_WAIT_CYCLES)
   ) u_reset_gen (
      .clk        (clk),
      .rst_n      (rst_n),
      .panel_rst  (panel_rst),
      .panel_ready(panel_ready)
   );

   lcd_init_seq #(
      .CYCLES_PER_MS(CYCLES_PER_MS)
   ) u_init_seq (
      .clk        (clk),
      .rst_n      (rst_n),
      .panel_ready(panel_ready),
      .grant      (init_grant),
      .done_byte  (init_done_byte),
      .req        (init_req),
      .start      (init_start),
      .dc         (init_dc),
      .init_done  (init_done),
      .byte_out   (init_byte)
   );

   pixel_streamer #(
      .SCREEN_WIDTH (SCREEN_WIDTH),
      .SCREEN_HEIGHT(SCREEN_HEIGHT)
   ) u_streamer (
      .clk       (clk),
      .rst_n     (rst_n),
      .init_done (init_done),
      .grant     (pix_grant),
      .done_byte (pix_done_byte),
      .color     (color),
      .req       (pix_req),
      .start     (pix_start),
      .dc        (pix_dc),
      .next_pixel(next_pixel),
      .is_init   (is_init),
      .byte_out  (pix_byte),
      .x         (x),
      .y         (y)
   );

   spi_bus_arbiter u_arbiter (
      .clk           (clk),
      .rst_n         (rst_n),
      .init_req      (init_req),
      .init_start    (init_start),
      .init_dc       (init_dc),
      .init_byte     (init_byte),
      .pix_req       (pix_req),
      .pix_start     (pix_start),
      .pix_dc        (pix_dc),
      .pix_byte      (pix_byte),
      .tx_busy       (tx_busy),
      .tx_done       (tx_done),
      .init_grant    (init_grant),
      .pix_grant     (pix_grant),
      .init_done_byte(init_done_byte),
      .pix_done_byte (pix_done_byte),
      .tx_start      (tx_start),
      .tx_dc         (tx_dc),
      .tx_byte       (tx_byte)
   );

   spi_byte_tx #(
      .HALF_SCK_CYCLES(HALF_SCK_CYCLES)
   ) u_spi_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .tx_start(tx_start),
      .tx_dc   (tx_dc),
      .tx_byte (tx_byte),
      .tx_busy (tx_busy),
      .tx_done (tx_done),
      .lcd_sck (lcd_sck),
      .lcd_mosi(lcd_mosi),
      .lcd_dc  (lcd_dc),
      .lcd_cs  (lcd_cs)
   );

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ns
/*
 * testbench clock and reset
 * free-running clock, reset held low for the first few cycles
 */
module tb_clock #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);   // released on the falling edge like other inputs
      rst_n = 1'b1;
   end

endmodule

//--- verif/st7735_tb.sv
`timescale 1ns/1ns
/*
 * ST7735 controller testbench
 * captures the SPI bytes with their DC level, answers next_pixel with a
 * colour per x/y, and runs directed tests over init, black fill and frames
 */
module st7735_tb import lcd_pkg::*;;

   localparam int SCR_W    = 4;
   localparam int SCR_H    = 3;
   localparam int XW       = $clog2(SCR_W);
   localparam int YW       = $clog2(SCR_H);
   localparam int CPM      = 2;              // cycles per ms in this run
   localparam int N_INIT   = 34;             // table ends with RAMWR
   localparam int N_FILL   = SCR_W * SCR_H * 2;
   localparam int FRAME_B  = 1 + N_FILL;     // RAMWR plus pixel bytes
   localparam int FRAME0   = N_INIT + N_FILL;
   localparam logic [BYTE_W-1:0] RAMWR = 8'h2C;

   // init table in send order
   localparam logic [BYTE_W-1:0] INIT_EXPECT [0:N_INIT-1] = '{
      8'h01, 8'h11, 8'hB4, 8'h07, 8'hC0, 8'hA2, 8'h02, 8'h84,
      8'hC3, 8'h8A, 8'h2A, 8'hC4, 8'h8A, 8'hEE, 8'hC5, 8'h0E,
      8'h21, 8'h36, 8'hC8, 8'h3A, 8'h05,
      8'h2A, 8'h00, 8'h1A, 8'h00, 8'h6A,
      8'h2B, 8'h00, 8'h01, 8'h00, 8'hA2,
      8'h13, 8'h29, 8'h2C
   };

   logic               clk;
   logic               rst_n;
   logic [COLOR_W-1:0] color = '0;
   logic               lcd_sck;
   logic               lcd_mosi;
   logic               lcd_dc;
   logic               lcd_cs;
   logic               panel_rst;
   logic               next_pixel;
   logic               is_init;
   logic [XW-1:0]      x;
   logic [YW-1:0]      y;

   logic [COLOR_W-1:0] color_base;
   int                 cycle = 0;
   int                 bit_cnt = 0;
   logic               sck_prev = 1'b1;
   logic [BYTE_W-1:0]  shift_in;
   int                 first_stamp;
   logic [XW-1:0]      last_x = '0;
   logic [YW-1:0]      last_y = '0;
   logic               sample_due = 1'b0;

   // one entry per captured byte
   logic [BYTE_W-1:0]  cap_byte[$];
   logic               cap_dc[$];
   logic               cap_init[$];
   int                 cap_first[$];
   int                 cap_last[$];
   logic [XW-1:0]      px_x[$];      // coordinates at each next_pixel
   logic [YW-1:0]      px_y[$];

   tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(4)) u_clock (
      .clk  (clk),
      .rst_n(rst_n)
   );

   st7735_ctrl #(
      .SCREEN_WIDTH     (SCR_W),
      .SCREEN_HEIGHT    (SCR_H),
      .HALF_SCK_CYCLES  (1),
      .CYCLES_PER_MS    (CPM),
      .RESET_LOW_CYCLES (10),
      .RESET_WAIT_CYCLES(20)
   ) u_st7735_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .color     (color),
      .lcd_sck   (lcd_sck),
      .lcd_mosi  (lcd_mosi),
      .lcd_dc    (lcd_dc),
      .lcd_cs    (lcd_cs),
      .panel_rst (panel_rst),
      .next_pixel(next_pixel),
      .is_init   (is_init),
      .x         (x),
      .y         (y)
   );

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_byte(input string name, input logic [BYTE_W-1:0] got,
                             input logic [BYTE_W-1:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         stop_on_error("byte value differs");
      end
   endtask

   task automatic check_color(input string name, input logic [COLOR_W-1:0] got,
                              input logic [COLOR_W-1:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         stop_on_error("pixel colour differs");
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s = %b, expected %b", $time, name, got, exp);
         stop_on_error("control level differs");
      end
   endtask

   task automatic check_pos(input string name, input logic [XW-1:0] gx, input logic [YW-1:0] gy,
                            input logic [XW-1:0] ex, input logic [YW-1:0] ey);
      if (gx !== ex || gy !== ey) begin
         $display("mismatch at %0t ns: %s = (%0d,%0d), expected (%0d,%0d)",
                  $time, name, gx, gy, ex, ey);
         stop_on_error("raster position differs");
      end
   endtask

   // command bytes of the init table go with dc low
   function automatic logic is_param_byte(input int idx);
      case (idx)
         0, 1, 2, 4, 8, 11, 14, 16, 17, 19, 21, 26, 31, 32, 33: return 1'b0;
         default: return 1'b1;
      endcase
   endfunction

   function automatic int pause_ms(input int idx);
      case (idx)
         0:       return 150;   // SWRESET
         1:       return 500;   // SLPOUT
         31:      return 10;    // NORON
         32:      return 100;   // DISPON
         default: return 0;
      endcase
   endfunction

   function automatic logic [COLOR_W-1:0] color_of(input int cx, input int cy);
      return color_base ^ COLOR_W'((cy * 37 + cx * 11 + 1) * 16'h0451);
   endfunction

   task automatic wait_captures(input int nb, input int np, input int limit,
                                input string what);
      int n;
      n = 0;
      while ((cap_byte.size() < nb || px_x.size() < np) && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (cap_byte.size() < nb || px_x.size() < np) begin
         stop_on_error($sformatf("timeout waiting for %s", what));
      end
   endtask

   always @(posedge clk) cycle <= cycle + 1;

   // SPI monitor samples the outputs mid-cycle
   always @(negedge clk) begin
      if (!rst_n) begin
         bit_cnt = 0;
      end else begin
         if (lcd_cs && bit_cnt != 0) begin
            stop_on_error("CS went high before all 8 bits of a byte were clocked");
         end
         if (!lcd_cs && lcd_sck && !sck_prev) begin   // sck rose this cycle
            if (bit_cnt == 0) first_stamp = cycle;
            shift_in = {shift_in[BYTE_W-2:0], lcd_mosi};
            bit_cnt++;
            if (bit_cnt == BYTE_W) begin
               cap_byte.push_back(shift_in);
               cap_dc.push_back(lcd_dc);
               cap_init.push_back(is_init);
               cap_first.push_back(first_stamp);
               cap_last.push_back(cycle);
               bit_cnt = 0;
            end
         end
      end
      sck_prev = lcd_sck;
   end

   // colour source: true colour only in the cycle after next_pixel
   always @(negedge clk) begin
      if (rst_n && next_pixel) begin
         px_x.push_back(x);
         px_y.push_back(y);
         last_x = x;
         last_y = y;
         color <= ~color_of(int'(x), int'(y));
         sample_due = 1'b1;
      end else if (sample_due) begin
         color <= color_of(int'(last_x), int'(last_y));
         sample_due = 1'b0;
      end else begin
         color <= ~color_of(int'(last_x), int'(last_y));   // inverted outside the window
      end
   end

   task automatic reset_behaviour();
      int n;
      n = 0;
      while (!rst_n && n < 20) begin
         @(posedge clk);
         n++;
      end
      if (!rst_n) stop_on_error("reset was never released");
      @(negedge clk);
      check_flag("panel_rst", panel_rst, 1'b0);
      check_flag("lcd_cs", lcd_cs, 1'b1);
      check_flag("lcd_sck", lcd_sck, 1'b1);
      check_flag("next_pixel", next_pixel, 1'b0);
      check_flag("is_init", is_init, 1'b0);
      n = 0;
      while (!panel_rst && n < 100) begin
         check_flag("lcd_cs", lcd_cs, 1'b1);   // no traffic during panel reset
         @(negedge clk);
         n++;
      end
      if (!panel_rst) stop_on_error("panel_rst never rose");
      if (cap_byte.size() != 0) stop_on_error("a byte was sent before panel_rst rose");
   endtask

   task automatic init_table_order();
      wait_captures(N_INIT, 0, 8000, "the init table bytes");
      for (int i = 0; i < N_INIT; i++) begin
         check_byte($sformatf("init byte %0d", i), cap_byte[i], INIT_EXPECT[i]);
         check_flag($sformatf("init dc %0d", i), cap_dc[i], is_param_byte(i));
      end
   endtask

   task automatic init_pauses();
      int gap;
      for (int i = 0; i < N_INIT - 1; i++) begin
         gap = cap_first[i+1] - cap_last[i];
         if (pause_ms(i) != 0 && gap < pause_ms(i) * CPM) begin
            stop_on_error($sformatf("pause after init entry %0d lasted only %0d cycles",
                                    i, gap));
         end
      end
   endtask

   task automatic black_frame_fill();
      wait_captures(FRAME0 + 1, 0, 3000, "the black frame");
      for (int i = N_INIT; i < FRAME0; i++) begin
         check_byte($sformatf("fill byte %0d", i - N_INIT), cap_byte[i], '0);
         check_flag($sformatf("fill dc %0d", i - N_INIT), cap_dc[i], 1'b1);
      end
      check_flag("is_init at last fill byte", cap_init[FRAME0-1], 1'b0);
      check_flag("is_init after fill", cap_init[FRAME0], 1'b1);
      if (px_x.size() != 0) stop_on_error("next_pixel pulsed during the black frame");
   endtask

   task automatic frame_raster_order();
      int k;
      wait_captures(FRAME0 + 2 * FRAME_B, 2 * SCR_W * SCR_H, 5000, "two streamed frames");
      for (int f = 0; f < 2; f++) begin
         check_byte($sformatf("frame %0d command", f), cap_byte[FRAME0 + f*FRAME_B], RAMWR);
         check_flag($sformatf("frame %0d command dc", f), cap_dc[FRAME0 + f*FRAME_B], 1'b0);
      end
      for (k = 0; k < 2 * SCR_W * SCR_H; k++) begin
         check_pos($sformatf("next_pixel %0d", k), px_x[k], px_y[k],
                   XW'(k % SCR_W), YW'((k / SCR_W) % SCR_H));
      end
   endtask

   task automatic pixel_colours();
      int b;
      for (int f = 0; f < 2; f++) begin
         for (int p = 0; p < SCR_W * SCR_H; p++) begin
            b = FRAME0 + f * FRAME_B + 1 + 2 * p;
            check_color($sformatf("frame %0d pixel %0d", f, p), {cap_byte[b], cap_byte[b+1]},
                        color_of(p % SCR_W, p / SCR_W));
            check_flag("pixel high byte dc", cap_dc[b], 1'b1);
            check_flag("pixel low byte dc", cap_dc[b+1], 1'b1);
         end
      end
   endtask

   task automatic frame_wrap();
      wait_captures(FRAME0 + 2 * FRAME_B + 1, 2 * SCR_W * SCR_H + 1, 2000, "a third frame");
      check_pos("first pixel of frame 1", px_x[SCR_W*SCR_H], px_y[SCR_W*SCR_H], '0, '0);
      check_pos("first pixel of frame 2", px_x[2*SCR_W*SCR_H], px_y[2*SCR_W*SCR_H], '0, '0);
      check_byte("frame 2 command", cap_byte[FRAME0 + 2*FRAME_B], RAMWR);
      check_flag("frame 2 command dc", cap_dc[FRAME0 + 2*FRAME_B], 1'b0);
   endtask

   initial begin
      void'($urandom(32'h3991_3342));
      color_base = COLOR_W'($urandom);
      reset_behaviour();
      init_table_order();
      init_pauses();
      black_frame_fill();
      frame_raster_order();
      pixel_colours();
      frame_wrap();
      $display("No errors");
      $finish;
   end

endmodule

//--- project.f
verilog/lcd_pkg.sv
verilog/panel_reset_gen.sv
verilog/spi_byte_tx.sv
verilog/lcd_init_seq.sv
verilog/pixel_streamer.sv
verilog/spi_bus_arbiter.sv
verilog/st7735_ctrl.sv
verif/tb_clock.sv
verif/st7735_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the ST7735 controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module st7735_tb \
   -f project.f -o Vst7735_tb

./obj_dir/Vst7735_tb | tee sim.log

if grep -q "No errors" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
